// File: rtl/decoding_graph_settings.svh
`ifndef DECODING_GRAPH_SETTINGS_SVH
`define DECODING_GRAPH_SETTINGS_SVH

// lattice size
`define GRID_WIDTH_X 4 // rows of checks, north to south
`define GRID_WIDTH_Z 2 // checks per row, west to east
`define GRID_WIDTH_U 3 // measurement rounds, one layer each

// grow steps until a link counts as fully grown
// every link has the same weight
`define MAX_WEIGHT 2

`endif

// File: rtl/decoding_graph_pkg.sv
`include "decoding_graph_settings.svh"

package decoding_graph_pkg;

    localparam int X_BIT_WIDTH = $clog2(`GRID_WIDTH_X);
    localparam int Z_BIT_WIDTH = $clog2(`GRID_WIDTH_Z);
    localparam int U_BIT_WIDTH = $clog2(`GRID_WIDTH_U);
    localparam int LINK_BIT_WIDTH = $clog2(`MAX_WEIGHT + 1);

    localparam int PU_COUNT_PER_ROUND = `GRID_WIDTH_X * `GRID_WIDTH_Z;
    localparam int PU_COUNT = PU_COUNT_PER_ROUND * `GRID_WIDTH_U;
    localparam int NEIGHBOR_COUNT = 6; // north, south, west, east, down, up

    typedef enum logic [1:0] {
        stage_idle,
        stage_load,
        stage_grow,
        stage_merge
    } stage_t;

    typedef struct packed {
        logic [U_BIT_WIDTH-1:0] round;
        logic [X_BIT_WIDTH-1:0] x;
        logic [Z_BIT_WIDTH-1:0] z;
    } address_t;

    typedef logic [LINK_BIT_WIDTH-1:0] link_count_t;

    typedef struct packed {
        address_t root;
        logic     occupied;    // cluster holds a defect
        logic     on_boundary; // cluster reaches a grown boundary link
    } pu_status_t;

    typedef pu_status_t [PU_COUNT-1:0] status_vec_t;

    // vertex position in status_vec_t to its address
    function automatic address_t vertex_address(int index);
        address_t addr;
        addr.round = U_BIT_WIDTH'(index / PU_COUNT_PER_ROUND);
        addr.x     = X_BIT_WIDTH'((index % PU_COUNT_PER_ROUND) / `GRID_WIDTH_Z);
        addr.z     = Z_BIT_WIDTH'(index % `GRID_WIDTH_Z);
        return addr;
    endfunction

endpackage

// File: rtl/measurement_round_loader.sv
`timescale 1ns/10ps
`include "decoding_graph_settings.svh"

module measurement_round_loader (
    input  logic                                              clk_i,
    input  logic                                              reset_i,
    input  decoding_graph_pkg::stage_t                        global_stage_i,
    input  logic [decoding_graph_pkg::PU_COUNT_PER_ROUND-1:0] measurements_i,
    output logic [decoding_graph_pkg::PU_COUNT-1:0]           defects_o
);

    import decoding_graph_pkg::*;

    // one slice per round, round 0 in the low slice
    logic [`GRID_WIDTH_U-1:0][PU_COUNT_PER_ROUND-1:0] rounds_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rounds_q <= '0;
        end else if (global_stage_i == stage_load) begin
            for (int k = 0; k < `GRID_WIDTH_U - 1; k++) begin
                rounds_q[k] <= rounds_q[k+1]; // older rounds sink one layer
            end
            rounds_q[`GRID_WIDTH_U-1] <= measurements_i; // newest round on top
        end
    end

    // slice order already matches vertex address order
    assign defects_o = rounds_q;

endmodule

// File: rtl/neighbor_link.sv
`timescale 1ns/10ps
`include "decoding_graph_settings.svh"

module neighbor_link (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  decoding_graph_pkg::stage_t global_stage_i,
    input  logic                       a_occupied_i,
    input  logic                       b_occupied_i,
    output logic                       fully_grown_o
);

    import decoding_graph_pkg::*;

    localparam link_count_t FULL_COUNT = link_count_t'(`MAX_WEIGHT);

    link_count_t             count_q;
    logic [LINK_BIT_WIDTH:0] grown_sum; // spare bit holds the overflow

    // each occupied endpoint pushes the link by one step
    assign grown_sum = count_q + a_occupied_i + b_occupied_i;

    always_ff @(posedge clk_i) begin
        if (reset_i || global_stage_i == stage_load) begin
            count_q <= '0;
        end else if (global_stage_i == stage_grow) begin
            if (grown_sum >= FULL_COUNT) begin
                count_q <= FULL_COUNT; // saturate
            end else begin
                count_q <= link_count_t'(grown_sum);
            end
        end
    end

    assign fully_grown_o = (count_q == FULL_COUNT);

endmodule

// File: rtl/processing_unit.sv
`timescale 1ns/10ps

module processing_unit #(
    parameter decoding_graph_pkg::address_t ADDRESS = '0
) (
    input  logic                                                    clk_i,
    input  logic                                                    reset_i,
    input  decoding_graph_pkg::stage_t                              global_stage_i,
    input  logic                                                    defect_i,
    input  logic [decoding_graph_pkg::NEIGHBOR_COUNT-1:0]           neighbor_grown_i,
    input  decoding_graph_pkg::pu_status_t [decoding_graph_pkg::NEIGHBOR_COUNT-1:0]
                                                                    neighbor_status_i,
    input  logic                                                    boundary_grown_i,
    output decoding_graph_pkg::pu_status_t                          status_o,
    output logic                                                    changed_o
);

    import decoding_graph_pkg::*;

    pu_status_t status_q;
    pu_status_t merged;
    stage_t     stage_q; // stage seen in the previous cycle
    logic       reload;
    logic       changed_q;

    // The loader presents a new round one cycle after it shifts, so the vertex
    // also reloads in the first cycle after the load stage ends. The controller
    // is expected to hold an idle cycle there before growing.
    assign reload = (global_stage_i == stage_load) || (stage_q == stage_load);

    // fold in every neighbor reached over a fully grown link
    always_comb begin
        merged = status_q;
        for (int n = 0; n < NEIGHBOR_COUNT; n++) begin
            if (neighbor_grown_i[n]) begin
                if (neighbor_status_i[n].root < merged.root) begin
                    merged.root = neighbor_status_i[n].root; // smallest address wins
                end
                merged.occupied    = merged.occupied | neighbor_status_i[n].occupied;
                merged.on_boundary = merged.on_boundary | neighbor_status_i[n].on_boundary;
            end
        end
        if (boundary_grown_i) begin
            merged.on_boundary = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            status_q  <= '{root: ADDRESS, occupied: 1'b0, on_boundary: 1'b0};
            stage_q   <= stage_idle;
            changed_q <= 1'b0;
        end else begin
            stage_q   <= global_stage_i;
            changed_q <= 1'b0; // only merge updates count as activity
            if (reload) begin
                status_q <= '{root: ADDRESS, occupied: defect_i, on_boundary: 1'b0};
            end else if (global_stage_i == stage_merge) begin
                status_q  <= merged;
                changed_q <= (merged != status_q);
            end
        end
    end

    assign status_o  = status_q;
    assign changed_o = changed_q;

endmodule

// File: rtl/decoding_graph_array.sv
`timescale 1ns/10ps
`include "decoding_graph_settings.svh"

module decoding_graph_array (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    input  decoding_graph_pkg::stage_t              global_stage_i,
    input  logic [decoding_graph_pkg::PU_COUNT-1:0] defects_i,
    output decoding_graph_pkg::status_vec_t         status_o,
    output logic [decoding_graph_pkg::PU_COUNT-1:0] changed_o
);

    import decoding_graph_pkg::*;

    localparam int DIR_NORTH = 0;
    localparam int DIR_SOUTH = 1;
    localparam int DIR_WEST  = 2;
    localparam int DIR_EAST  = 3;
    localparam int DIR_DOWN  = 4;
    localparam int DIR_UP    = 5;

    // both ends of an internal link read the same grown flag
    wire [NEIGHBOR_COUNT-1:0] link_grown [PU_COUNT];
    wire [PU_COUNT-1:0]       boundary_grown;

    for (genvar k = 0; k < `GRID_WIDTH_U; k++) begin : g_round
        for (genvar i = 0; i < `GRID_WIDTH_X; i++) begin : g_row
            for (genvar j = 0; j < `GRID_WIDTH_Z; j++) begin : g_col
                localparam int V = k * PU_COUNT_PER_ROUND + i * `GRID_WIDTH_Z + j;
                // missing neighbors point back at the vertex itself
                localparam int NORTH_V = (i > 0) ? V - `GRID_WIDTH_Z : V;
                localparam int SOUTH_V = (i < `GRID_WIDTH_X - 1) ? V + `GRID_WIDTH_Z : V;
                localparam int WEST_V  = (j > 0) ? V - 1 : V;
                localparam int EAST_V  = (j < `GRID_WIDTH_Z - 1) ? V + 1 : V;
                localparam int DOWN_V  = (k > 0) ? V - PU_COUNT_PER_ROUND : V;
                localparam int UP_V    = (k < `GRID_WIDTH_U - 1) ? V + PU_COUNT_PER_ROUND : V;

                pu_status_t [NEIGHBOR_COUNT-1:0] neighbor_status;

                assign neighbor_status[DIR_NORTH] = status_o[NORTH_V];
                assign neighbor_status[DIR_SOUTH] = status_o[SOUTH_V];
                assign neighbor_status[DIR_WEST]  = status_o[WEST_V];
                assign neighbor_status[DIR_EAST]  = status_o[EAST_V];
                assign neighbor_status[DIR_DOWN]  = status_o[DOWN_V];
                assign neighbor_status[DIR_UP]    = status_o[UP_V];

                processing_unit #(
                    .ADDRESS(vertex_address(V))
                ) u_pu (
                    .clk_i            (clk_i),
                    .reset_i          (reset_i),
                    .global_stage_i   (global_stage_i),
                    .defect_i         (defects_i[V]),
                    .neighbor_grown_i (link_grown[V]),
                    .neighbor_status_i(neighbor_status),
                    .boundary_grown_i (boundary_grown[V]),
                    .status_o         (status_o[V]),
                    .changed_o        (changed_o[V])
                );

                // each vertex owns its south, east and up links
                if (i < `GRID_WIDTH_X - 1) begin : g_south
                    neighbor_link u_link (
                        .clk_i(clk_i), .reset_i(reset_i), .global_stage_i(global_stage_i),
                        .a_occupied_i (status_o[V].occupied),
                        .b_occupied_i (status_o[SOUTH_V].occupied),
                        .fully_grown_o(link_grown[V][DIR_SOUTH])
                    );
                    assign link_grown[SOUTH_V][DIR_NORTH] = link_grown[V][DIR_SOUTH];
                end else begin : g_no_south
                    assign link_grown[V][DIR_SOUTH] = 1'b0;
                end

                if (j < `GRID_WIDTH_Z - 1) begin : g_east
                    neighbor_link u_link (
                        .clk_i(clk_i), .reset_i(reset_i), .global_stage_i(global_stage_i),
                        .a_occupied_i (status_o[V].occupied),
                        .b_occupied_i (status_o[EAST_V].occupied),
                        .fully_grown_o(link_grown[V][DIR_EAST])
                    );
                    assign link_grown[EAST_V][DIR_WEST] = link_grown[V][DIR_EAST];
                end else begin : g_no_east
                    assign link_grown[V][DIR_EAST] = 1'b0;
                end

                if (k < `GRID_WIDTH_U - 1) begin : g_up
                    neighbor_link u_link (
                        .clk_i(clk_i), .reset_i(reset_i), .global_stage_i(global_stage_i),
                        .a_occupied_i (status_o[V].occupied),
                        .b_occupied_i (status_o[UP_V].occupied),
                        .fully_grown_o(link_grown[V][DIR_UP])
                    );
                    assign link_grown[UP_V][DIR_DOWN] = link_grown[V][DIR_UP];
                end else begin : g_no_up
                    assign link_grown[V][DIR_UP] = 1'b0;
                end

                if (i == 0) begin : g_no_north
                    assign link_grown[V][DIR_NORTH] = 1'b0;
                end
                if (j == 0) begin : g_no_west
                    assign link_grown[V][DIR_WEST] = 1'b0;
                end
                if (k == 0) begin : g_no_down
                    assign link_grown[V][DIR_DOWN] = 1'b0;
                end

                // north edge of row 0 and south edge of the last row
                if (i == 0 || i == `GRID_WIDTH_X - 1) begin : g_boundary
                    neighbor_link u_link (
                        .clk_i(clk_i), .reset_i(reset_i), .global_stage_i(global_stage_i),
                        .a_occupied_i (status_o[V].occupied),
                        .b_occupied_i (1'b0), // single endpoint
                        .fully_grown_o(boundary_grown[V])
                    );
                end else begin : g_no_boundary
                    assign boundary_grown[V] = 1'b0;
                end
            end
        end
    end

endmodule

// File: rtl/status_collector.sv
`timescale 1ns/10ps

module status_collector (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    input  decoding_graph_pkg::status_vec_t         status_i,
    input  logic [decoding_graph_pkg::PU_COUNT-1:0] changed_i,
    output decoding_graph_pkg::status_vec_t         status_o,
    output logic                                    busy_o
);

    import decoding_graph_pkg::*;

    status_vec_t status_q;
    logic        busy_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int v = 0; v < PU_COUNT; v++) begin
                status_q[v] <= '{root: vertex_address(v), occupied: 1'b0, on_boundary: 1'b0};
            end
            busy_q <= 1'b0;
        end else begin
            status_q <= status_i;
            busy_q   <= |changed_i; // any vertex still moving
        end
    end

    assign status_o = status_q;
    assign busy_o   = busy_q;

endmodule

// File: rtl/decoding_graph.sv
`timescale 1ns/10ps

module decoding_graph (
    input  logic                                              clk_i,
    input  logic                                              reset_i,
    input  decoding_graph_pkg::stage_t                        global_stage_i,
    input  logic [decoding_graph_pkg::PU_COUNT_PER_ROUND-1:0] measurements_i,
    output decoding_graph_pkg::status_vec_t                   status_o,
    output logic                                              busy_o
);

    import decoding_graph_pkg::*;

    logic [PU_COUNT-1:0] defects;
    status_vec_t         array_status;
    logic [PU_COUNT-1:0] array_changed;

    measurement_round_loader u_loader (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .global_stage_i(global_stage_i),
        .measurements_i(measurements_i),
        .defects_o     (defects)
    );

    decoding_graph_array u_array (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .global_stage_i(global_stage_i),
        .defects_i     (defects),
        .status_o      (array_status),
        .changed_o     (array_changed)
    );

    status_collector u_collector (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .status_i (array_status),
        .changed_i(array_changed),
        .status_o (status_o),
        .busy_o   (busy_o)
    );

endmodule

// File: dv/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    initial clk_o = 1'b0;
    always #(PERIOD_NS / 2) clk_o = ~clk_o; // 50 ns high, 50 ns low

endmodule

// File: dv/decoding_graph_props.sv
`timescale 1ns/10ps
`include "decoding_graph_settings.svh"

module decoding_graph_props (
    input logic                            clk_i,
    input logic                            reset_i,
    input decoding_graph_pkg::stage_t      global_stage_i,
    input decoding_graph_pkg::status_vec_t status_i,
    input logic                            busy_i
);

    import decoding_graph_pkg::*;

    int failure_count = 0; // read by the testbench at the end of the run

    busy_after_reset: assert property (@(posedge clk_i) reset_i |=> !busy_i)
        else begin
            failure_count++;
            $error("busy high in the cycle after reset");
        end

    // a load stops all merge activity and busy lags one more cycle
    busy_after_load: assert property (@(posedge clk_i) disable iff (reset_i)
        global_stage_i == stage_load |-> ##2 !busy_i)
        else begin
            failure_count++;
            $error("busy still high two cycles after a load");
        end

    for (genvar v = 0; v < PU_COUNT; v++) begin : g_root
        localparam address_t OWN = {U_BIT_WIDTH'(v / PU_COUNT_PER_ROUND),
                                    X_BIT_WIDTH'((v % PU_COUNT_PER_ROUND) / `GRID_WIDTH_Z),
                                    Z_BIT_WIDTH'(v % `GRID_WIDTH_Z)};
        // roots only ever move toward smaller addresses
        root_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
            status_i[v].root <= OWN)
            else begin
                failure_count++;
                $error("vertex %0d holds a root above its own address", v);
            end
    end

endmodule

bind decoding_graph decoding_graph_props i_decoding_graph_props (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .global_stage_i(global_stage_i),
    .status_i      (status_o),
    .busy_i        (busy_o)
);

// File: dv/decoding_graph_tb.sv
`timescale 1ns/10ps
`include "decoding_graph_settings.svh"

module decoding_graph_tb;

    import decoding_graph_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 5; // ns after the rising edge
    localparam int DIRECTED     = 4;
    localparam int ROW_COUNT    = DIRECTED + 6;

    typedef logic [`GRID_WIDTH_U-1:0][PU_COUNT_PER_ROUND-1:0] rounds_t;

    typedef struct packed {
        rounds_t     pattern;  // round 0 is loaded first
        int          grows;
        int          spot_v;   // vertex with a literal expectation, -1 if none
        pu_status_t  spot;
        status_vec_t expected; // filled by the reference model
    } row_t;

    logic                          clk;
    logic                          reset;
    stage_t                        stage;
    logic [PU_COUNT_PER_ROUND-1:0] measurements;
    status_vec_t                   status;
    logic                          busy;
    row_t                          table_q [ROW_COUNT];
    int                            checks;
    int                            errors;
    int                            watchdog_cycles;

    clock_gen #(.PERIOD_NS(100)) i_clock_gen (.clk_o(clk));

    decoding_graph i_decoding_graph (
        .clk_i         (clk),
        .reset_i       (reset),
        .global_stage_i(stage),
        .measurements_i(measurements),
        .status_o      (status),
        .busy_o        (busy)
    );

    function automatic int vertex_index(int k, int i, int j);
        return k * PU_COUNT_PER_ROUND + i * `GRID_WIDTH_Z + j;
    endfunction

    // packed as round, then row, then column
    function automatic address_t make_addr(int k, int i, int j);
        address_t a;
        a.round = U_BIT_WIDTH'(k);
        a.x     = X_BIT_WIDTH'(i);
        a.z     = Z_BIT_WIDTH'(j);
        return a;
    endfunction

    function automatic bit is_grown(int grows, int occupied_ends);
        return grows * occupied_ends >= `MAX_WEIGHT; // saturating count reached the weight
    endfunction

    function automatic row_t directed_row(rounds_t pattern, int grows, int spot_v,
                                          address_t root, bit occupied, bit on_boundary);
        row_t r;
        r = '0;
        r.pattern = pattern;
        r.grows   = grows;
        r.spot_v  = spot_v;
        r.spot    = '{root: root, occupied: occupied, on_boundary: on_boundary};
        return r;
    endfunction

    // connected components over grown links, by repeated pairwise joining
    function automatic status_vec_t model_status(row_t r);
        status_vec_t         s;
        pu_status_t          m;
        logic [PU_COUNT-1:0] defect;
        int                  a;
        int                  b;
        bit                  moved;
        for (int k = 0; k < `GRID_WIDTH_U; k++) begin
            for (int i = 0; i < `GRID_WIDTH_X; i++) begin
                for (int j = 0; j < `GRID_WIDTH_Z; j++) begin
                    a = vertex_index(k, i, j);
                    defect[a] = r.pattern[k][i * `GRID_WIDTH_Z + j];
                    s[a].root = make_addr(k, i, j);
                    s[a].occupied = defect[a];
                    s[a].on_boundary = (i == 0 || i == `GRID_WIDTH_X - 1)
                                       && is_grown(r.grows, int'(defect[a]));
                end
            end
        end
        do begin
            moved = 0;
            for (int k = 0; k < `GRID_WIDTH_U; k++) begin
                for (int i = 0; i < `GRID_WIDTH_X; i++) begin
                    for (int j = 0; j < `GRID_WIDTH_Z; j++) begin
                        a = vertex_index(k, i, j);
                        for (int d = 0; d < 3; d++) begin
                            // south, east and up neighbors
                            b = (d == 0 && i < `GRID_WIDTH_X - 1) ? a + `GRID_WIDTH_Z :
                                (d == 1 && j < `GRID_WIDTH_Z - 1) ? a + 1 :
                                (d == 2 && k < `GRID_WIDTH_U - 1) ? a + PU_COUNT_PER_ROUND : -1;
                            if (b >= 0 && s[a] != s[b]
                                && is_grown(r.grows, int'(defect[a]) + int'(defect[b]))) begin
                                m = s[a];
                                if (s[b].root < m.root) m.root = s[b].root;
                                m.occupied    = m.occupied | s[b].occupied;
                                m.on_boundary = m.on_boundary | s[b].on_boundary;
                                s[a]  = m;
                                s[b]  = m;
                                moved = 1;
                            end
                        end
                    end
                end
            end
        end while (moved);
        return s;
    endfunction

    task automatic build_table();
        rounds_t p;
        // distinct rounds, adjacent pair, interior spread, row 0 boundary
        table_q[0] = directed_row({8'h80, 8'h06, 8'h01}, 0, vertex_index(2, 3, 1),
                                  make_addr(2, 3, 1), 1'b1, 1'b0);
        table_q[1] = directed_row({8'h00, 8'h4C, 8'h00}, 1, vertex_index(1, 1, 1),
                                  make_addr(1, 1, 0), 1'b1, 1'b0);
        table_q[2] = directed_row({8'h00, 8'h04, 8'h00}, 2, vertex_index(2, 1, 0),
                                  make_addr(0, 1, 0), 1'b1, 1'b0);
        table_q[3] = directed_row({8'h20, 8'h00, 8'h01}, 2, vertex_index(1, 0, 0),
                                  make_addr(0, 0, 0), 1'b1, 1'b1);
        for (int n = DIRECTED; n < ROW_COUNT; n++) begin
            for (int k = 0; k < `GRID_WIDTH_U; k++) begin
                p[k] = PU_COUNT_PER_ROUND'($urandom & $urandom); // sparse defects
            end
            table_q[n] = directed_row(p, $urandom % 4, -1, '0, 1'b0, 1'b0);
        end
        watchdog_cycles = RESET_CYCLES;
        for (int n = 0; n < ROW_COUNT; n++) begin
            table_q[n].expected = model_status(table_q[n]);
            watchdog_cycles += 2 * (3 + table_q[n].grows + PU_COUNT + 4);
        end
    endtask

    task automatic drive(stage_t st, logic [PU_COUNT_PER_ROUND-1:0] m);
        @(posedge clk);
        #DRIVE_DELAY;
        stage        = st;
        measurements = m;
    endtask

    task automatic compare(int n, int v, pu_status_t exp);
        checks++;
        assert (status[v] === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d vertex %0d status %h, expected %h",
                     $time, n, v, status[v], exp);
        end
    endtask

    task automatic check_reset();
        int start_errors;
        start_errors = errors;
        for (int v = 0; v < PU_COUNT; v++) begin
            compare(-1, v, '{root: make_addr(v / PU_COUNT_PER_ROUND,
                     (v % PU_COUNT_PER_ROUND) / `GRID_WIDTH_Z, v % `GRID_WIDTH_Z),
                     occupied: 1'b0, on_boundary: 1'b0});
        end
        checks++;
        assert (busy === 1'b0) else begin
            errors++;
            $display("CHECK FAILED at %0t: busy high after reset", $time);
        end
        $display("reset: %s", (errors == start_errors) ? "ok" : "mismatch");
    endtask

    task automatic apply_row(int n);
        row_t r;
        int   merges;
        int   start_errors;
        r = table_q[n];
        start_errors = errors;
        for (int k = 0; k < `GRID_WIDTH_U; k++) drive(stage_load, r.pattern[k]);
        drive(stage_idle, '0); // vertices pick up the last round here
        for (int g = 0; g < r.grows; g++) drive(stage_grow, '0);
        drive(stage_merge, '0);
        merges = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            merges++;
        end while (merges < 2 || busy);
        for (int v = 0; v < PU_COUNT; v++) compare(n, v, r.expected[v]);
        if (r.spot_v >= 0) compare(n, r.spot_v, r.spot);
        $display("row %0d: %0d grows, %0d merge cycles, %s", n, r.grows, merges,
                 (errors == start_errors) ? "ok" : "mismatch");
    endtask

    initial begin
        reset        = 1'b1;
        stage        = stage_idle;
        measurements = '0;
        checks       = 0;
        errors       = 0;
        void'($urandom(50));
        build_table();
        fork
            begin
                repeat (watchdog_cycles) @(posedge clk);
                $display("TIMEOUT at %0t: merge never finished within %0d cycles",
                         $time, watchdog_cycles);
                $display("Test failed");
                $finish;
            end
        join_none
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        check_reset();
        for (int n = 0; n < ROW_COUNT; n++) apply_row(n);
        errors += i_decoding_graph.i_decoding_graph_props.failure_count; // bound properties
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+rtl
rtl/decoding_graph_pkg.sv
rtl/measurement_round_loader.sv
rtl/neighbor_link.sv
rtl/processing_unit.sv
rtl/decoding_graph_array.sv
rtl/status_collector.sv
rtl/decoding_graph.sv
dv/clock_gen.sv
dv/decoding_graph_props.sv
dv/decoding_graph_tb.sv
